// File: design/exec_settings.svh
/*
 * Widths, bus unit select codes, integer ALU register offsets
 * and opcode values for the execution engine
 */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define EXEC_DATA_WIDTH      16
`define EXEC_PC_WIDTH        12
`define EXEC_NUM_REGS        16
`define EXEC_MAIN_ALIGN_BITS 7

// Upper address nibble
`define EXEC_UNIT_MAIN    4'h0
`define EXEC_UNIT_INSTR   4'h1
`define EXEC_UNIT_INT_ALU 4'h3

// Integer ALU register map
`define EXEC_ALU_SRC1   12'h000
`define EXEC_ALU_SRC2   12'h001
`define EXEC_ALU_CMD    12'h002
`define EXEC_ALU_STATUS 12'h003
`define EXEC_ALU_RESULT 12'h004

`define EXEC_OP_IADD  8'h10
`define EXEC_OP_ISUB  8'h11
`define EXEC_OP_IMULT 8'h12
`define EXEC_OP_IDIV  8'h13
`define EXEC_OP_BNE   8'h20
`define EXEC_OP_BEQ   8'h21
`define EXEC_OP_BLT   8'h22
`define EXEC_OP_BGT   8'h23
`define EXEC_OP_HALT  8'hFF

// Field upper nibble for register operands
`define EXEC_REG_TAG 4'h1

`endif

// File: design/exec_pkg.sv
/*
 * Data, address and index types, operation kind
 * and the bus sequencer state encoding
 */
`include "exec_settings.svh"

package exec_pkg;

    typedef logic [`EXEC_DATA_WIDTH-1:0]       word_t;
    typedef logic [`EXEC_PC_WIDTH-1:0]         pc_t;
    typedef logic [`EXEC_PC_WIDTH+3:0]         bus_addr_t;
    typedef logic [$clog2(`EXEC_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [7:0]                        opcode_t;
    typedef logic [31:0]                       instr_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_INT,
        KIND_BRANCH
    } op_kind_t;

    typedef enum logic [4:0] {
        st_reset,
        st_fetch_hi,
        st_fetch_lo,
        st_decode,
        st_read_req,
        st_read_wait,
        st_post_read,
        st_alu_src1,
        st_alu_src2,
        st_alu_cmd,
        st_status_poll,
        st_result_read,
        st_branch_eval,
        st_store,
        st_writeback,
        st_complete,
        st_halt
    } seq_state_t;

endpackage

// File: design/instr_decode.sv
/*
 * Instruction register, loaded as two 16-bit halves,
 * and classification of the captured instruction fields
 */
`timescale 1ns/1ps
`include "exec_settings.svh"

module instr_decode (
    input  logic                Clk,
    input  logic                nReset,
    input  logic                instr_load,
    input  logic                instr_half,
    input  exec_pkg::word_t     rdata,
    output exec_pkg::opcode_t   opcode,
    output exec_pkg::op_kind_t  kind,
    output logic                is_halt,
    output logic                dest_is_reg,
    output logic                src_a_is_reg,
    output logic                src_b_is_reg,
    output exec_pkg::reg_idx_t  dest_idx,
    output exec_pkg::reg_idx_t  src_a_idx,
    output exec_pkg::reg_idx_t  src_b_idx,
    output exec_pkg::pc_t       dest_addr,
    output exec_pkg::pc_t       src_a_addr,
    output exec_pkg::pc_t       src_b_addr,
    output exec_pkg::pc_t       branch_offset
);
    import exec_pkg::*;

    localparam int INDEX_BITS = `EXEC_PC_WIDTH - `EXEC_MAIN_ALIGN_BITS;

    instr_t     instr_reg;
    logic [7:0] dest_field;
    logic [7:0] src_a_field;
    logic [7:0] src_b_field;

    // Main memory word index sits above the alignment bits
    function automatic pc_t main_addr(input logic [7:0] field);
        return {field[INDEX_BITS-1:0], {`EXEC_MAIN_ALIGN_BITS{1'b0}}};
    endfunction

    // High half arrives first
    always_ff @(posedge Clk or negedge nReset) begin
        if (!nReset) begin
            instr_reg <= '0;
        end else if (instr_load) begin
            if (instr_half) begin
                instr_reg[31:16] <= rdata;
            end else begin
                instr_reg[15:0] <= rdata;
            end
        end
    end

    assign opcode      = instr_reg[31:24];
    assign dest_field  = instr_reg[23:16];
    assign src_a_field = instr_reg[15:8];
    assign src_b_field = instr_reg[7:0];

    always_comb begin
        case (opcode)
            `EXEC_OP_IADD, `EXEC_OP_ISUB, `EXEC_OP_IMULT, `EXEC_OP_IDIV: kind = KIND_INT;
            `EXEC_OP_BEQ, `EXEC_OP_BNE, `EXEC_OP_BLT, `EXEC_OP_BGT:     kind = KIND_BRANCH;
            default:                                                    kind = KIND_NONE;
        endcase
    end

    assign is_halt = (opcode == `EXEC_OP_HALT);

    assign dest_is_reg  = (dest_field[7:4] == `EXEC_REG_TAG);
    assign src_a_is_reg = (src_a_field[7:4] == `EXEC_REG_TAG);
    assign src_b_is_reg = (src_b_field[7:4] == `EXEC_REG_TAG);

    assign dest_idx  = dest_field[3:0];
    assign src_a_idx = src_a_field[3:0];
    assign src_b_idx = src_b_field[3:0];

    assign dest_addr  = main_addr(dest_field);
    assign src_a_addr = main_addr(src_a_field);
    assign src_b_addr = main_addr(src_b_field);

    // Destination field doubles as signed branch offset
    assign branch_offset = {{(`EXEC_PC_WIDTH-8){dest_field[7]}}, dest_field};

endmodule

// File: design/reg_file.sv
/*
 * Sixteen-entry register file, two read ports, one write port
 */
`timescale 1ns/1ps
`include "exec_settings.svh"

module reg_file (
    input  logic                Clk,
    input  logic                nReset,
    input  exec_pkg::reg_idx_t  rd_a_idx,
    input  exec_pkg::reg_idx_t  rd_b_idx,
    input  exec_pkg::reg_idx_t  wr_idx,
    input  logic                we,
    input  exec_pkg::word_t     wdata,
    output exec_pkg::word_t     rd_a,
    output exec_pkg::word_t     rd_b
);
    import exec_pkg::*;

    word_t regs [`EXEC_NUM_REGS];

    always_ff @(posedge Clk or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wdata;
        end
    end

    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];

endmodule

// File: design/pc_branch.sv
/*
 * Program counter with next-pc register and branch test
 */
`timescale 1ns/1ps
`include "exec_settings.svh"

module pc_branch (
    input  logic               Clk,
    input  logic               nReset,
    input  exec_pkg::opcode_t  opcode,
    input  exec_pkg::word_t    src_a,
    input  exec_pkg::word_t    src_b,
    input  exec_pkg::pc_t      branch_offset,
    input  logic               branch_eval,
    input  logic               pc_advance,
    output exec_pkg::pc_t      pc
);
    import exec_pkg::*;

    pc_t  next_pc;
    logic take;

    always_comb begin
        case (opcode)
            `EXEC_OP_BEQ: take = (src_a == src_b);
            `EXEC_OP_BNE: take = (src_a != src_b);
            `EXEC_OP_BLT: take = ($signed(src_a) < $signed(src_b));
            `EXEC_OP_BGT: take = ($signed(src_a) > $signed(src_b));
            default:      take = 1'b0;
        endcase
    end

    // next_pc already holds pc+1 when the new instruction arrives
    always_ff @(posedge Clk or negedge nReset) begin
        if (!nReset) begin
            pc      <= '0;
            next_pc <= pc_t'(1);
        end else if (pc_advance) begin
            pc      <= next_pc;
            next_pc <= next_pc + pc_t'(1);
        end else if (branch_eval && take) begin
            next_pc <= pc + branch_offset;
        end
    end

endmodule

// File: design/bus_sequencer.sv
/*
 * Bus master FSM: instruction fetch, operand reads, integer ALU
 * dispatch and polling, branch evaluation and result store
 */
`timescale 1ns/1ps
`include "exec_settings.svh"

module bus_sequencer (
    input  logic                Clk,
    input  logic                nReset,
    input  exec_pkg::opcode_t   opcode,
    input  exec_pkg::op_kind_t  kind,
    input  logic                is_halt,
    input  logic                dest_is_reg,
    input  logic                src_a_is_reg,
    input  logic                src_b_is_reg,
    input  exec_pkg::pc_t       dest_addr,
    input  exec_pkg::pc_t       src_a_addr,
    input  exec_pkg::pc_t       src_b_addr,
    input  exec_pkg::word_t     reg_rd_a,
    input  exec_pkg::word_t     reg_rd_b,
    input  exec_pkg::word_t     rdata,
    input  exec_pkg::pc_t       pc,
    output exec_pkg::bus_addr_t address,
    output logic                nRead,
    output logic                nWrite,
    output logic                halted,
    output exec_pkg::word_t     wdata,
    output logic                instr_load,
    output logic                instr_half,
    output logic                reg_we,
    output logic                branch_eval,
    output logic                pc_advance,
    output exec_pkg::word_t     reg_wdata,
    output exec_pkg::word_t     src_a,
    output exec_pkg::word_t     src_b
);
    import exec_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    logic       phase;
    logic       phase_next;
    logic       src_a_ready;
    logic       src_b_ready;
    logic       read_sel;
    word_t      result;
    pc_t        read_addr;

    // Operand A is always fetched first, so a ready A means B is pending
    assign read_sel  = src_a_ready;
    assign read_addr = read_sel ? src_b_addr : src_a_addr;

    assign halted    = (state == st_halt);
    assign reg_wdata = result;

    always_comb begin
        state_next  = state;
        phase_next  = 1'b0;
        address     = '0;
        nRead       = 1'b1;
        nWrite      = 1'b1;
        wdata       = '0;
        instr_load  = 1'b0;
        instr_half  = 1'b0;
        reg_we      = 1'b0;
        branch_eval = 1'b0;
        pc_advance  = 1'b0;

        case (state)
            st_reset: state_next = st_fetch_hi;
            st_fetch_hi, st_fetch_lo: begin
                instr_half = (state == st_fetch_hi);
                address    = {`EXEC_UNIT_INSTR, pc[`EXEC_PC_WIDTH-2:0], ~instr_half};
                nRead      = 1'b0;
                phase_next = ~phase;
                if (phase) begin
                    instr_load = 1'b1;
                    state_next = instr_half ? st_fetch_lo : st_decode;
                end
            end
            st_decode: begin
                if (is_halt) begin
                    state_next = st_halt;
                end else if (kind == KIND_NONE) begin
                    state_next = st_complete;
                end else begin
                    state_next = st_post_read;
                end
            end
            st_post_read: begin
                if (!src_a_ready || !src_b_ready) begin
                    state_next = st_read_req;
                end else if (kind == KIND_INT) begin
                    state_next = st_alu_src1;
                end else begin
                    state_next = st_branch_eval;
                end
            end
            st_read_req, st_read_wait: begin
                address    = {`EXEC_UNIT_MAIN, read_addr};
                nRead      = 1'b0;
                state_next = (state == st_read_req) ? st_read_wait : st_post_read;
            end
            // ALU writes: one strobe cycle, one idle cycle
            st_alu_src1, st_alu_src2, st_alu_cmd: begin
                phase_next = ~phase;
                if (!phase) begin
                    nWrite = 1'b0;
                    case (state)
                        st_alu_src1: begin
                            address = {`EXEC_UNIT_INT_ALU, `EXEC_ALU_SRC1};
                            wdata   = src_a;
                        end
                        st_alu_src2: begin
                            address = {`EXEC_UNIT_INT_ALU, `EXEC_ALU_SRC2};
                            wdata   = src_b;
                        end
                        default: begin
                            address = {`EXEC_UNIT_INT_ALU, `EXEC_ALU_CMD};
                            wdata   = {{(`EXEC_DATA_WIDTH-8){1'b0}}, opcode};
                        end
                    endcase
                end else begin
                    case (state)
                        st_alu_src1: state_next = st_alu_src2;
                        st_alu_src2: state_next = st_alu_cmd;
                        default:     state_next = st_status_poll;
                    endcase
                end
            end
            st_status_poll: begin
                address = {`EXEC_UNIT_INT_ALU, `EXEC_ALU_STATUS};
                nRead   = 1'b0;
                if (phase && rdata[0]) begin
                    state_next = st_result_read;
                end else begin
                    phase_next = 1'b1;
                end
            end
            st_result_read: begin
                address    = {`EXEC_UNIT_INT_ALU, `EXEC_ALU_RESULT};
                nRead      = 1'b0;
                phase_next = ~phase;
                if (phase) begin
                    state_next = st_store;
                end
            end
            st_branch_eval: begin
                branch_eval = 1'b1;
                state_next  = st_complete;
            end
            st_store: begin
                reg_we     = dest_is_reg;
                state_next = dest_is_reg ? st_complete : st_writeback;
            end
            st_writeback: begin
                address    = {`EXEC_UNIT_MAIN, dest_addr};
                wdata      = result;
                nWrite     = 1'b0;
                phase_next = ~phase;
                if (phase) begin
                    state_next = st_complete;
                end
            end
            st_complete: begin
                pc_advance = 1'b1;
                state_next = st_fetch_hi;
            end
            st_halt: state_next = st_halt;
            default: state_next = st_reset;
        endcase
    end

    always_ff @(posedge Clk or negedge nReset) begin
        if (!nReset) begin
            state       <= st_reset;
            phase       <= 1'b0;
            src_a_ready <= 1'b0;
            src_b_ready <= 1'b0;
        end else begin
            state <= state_next;
            phase <= phase_next;
            if (state == st_decode) begin
                src_a_ready <= src_a_is_reg;
                src_b_ready <= src_b_is_reg;
            end else if (state == st_read_wait) begin
                if (read_sel) begin
                    src_b_ready <= 1'b1;
                end else begin
                    src_a_ready <= 1'b1;
                end
            end
        end
    end

    // Operand and result capture
    always_ff @(posedge Clk) begin
        case (state)
            st_decode: begin
                if (src_a_is_reg) begin
                    src_a <= reg_rd_a;
                end
                if (src_b_is_reg) begin
                    src_b <= reg_rd_b;
                end
            end
            st_read_wait: begin
                if (read_sel) begin
                    src_b <= rdata;
                end else begin
                    src_a <= rdata;
                end
            end
            st_result_read: begin
                if (phase) begin
                    result <= rdata;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: design/exec_top.sv
/*
 * Execution engine top: decoder, register file,
 * pc unit and bus sequencer
 */
`timescale 1ns/1ps

module exec_top (
    input  logic                Clk,
    input  logic                nReset,
    output exec_pkg::bus_addr_t address,
    output logic                nRead,
    output logic                nWrite,
    output exec_pkg::word_t     wdata,
    input  exec_pkg::word_t     rdata,
    output logic                halted
);
    import exec_pkg::*;

    opcode_t  opcode;
    op_kind_t kind;
    logic     is_halt;
    logic     dest_is_reg;
    logic     src_a_is_reg;
    logic     src_b_is_reg;
    reg_idx_t dest_idx;
    reg_idx_t src_a_idx;
    reg_idx_t src_b_idx;
    pc_t      dest_addr;
    pc_t      src_a_addr;
    pc_t      src_b_addr;
    pc_t      branch_offset;
    pc_t      pc;
    logic     instr_load;
    logic     instr_half;
    logic     reg_we;
    logic     branch_eval;
    logic     pc_advance;
    word_t    reg_wdata;
    word_t    reg_rd_a;
    word_t    reg_rd_b;
    word_t    src_a;
    word_t    src_b;

    instr_decode decode_i (
        .Clk, .nReset, .instr_load, .instr_half, .rdata,
        .opcode, .kind, .is_halt,
        .dest_is_reg, .src_a_is_reg, .src_b_is_reg,
        .dest_idx, .src_a_idx, .src_b_idx,
        .dest_addr, .src_a_addr, .src_b_addr,
        .branch_offset
    );

    reg_file regs_i (
        .Clk, .nReset,
        .rd_a_idx (src_a_idx),
        .rd_b_idx (src_b_idx),
        .wr_idx   (dest_idx),
        .we       (reg_we),
        .wdata    (reg_wdata),
        .rd_a     (reg_rd_a),
        .rd_b     (reg_rd_b)
    );

    pc_branch pc_i (
        .Clk, .nReset, .opcode, .src_a, .src_b,
        .branch_offset, .branch_eval, .pc_advance, .pc
    );

    bus_sequencer seq_i (
        .Clk, .nReset, .opcode, .kind, .is_halt,
        .dest_is_reg, .src_a_is_reg, .src_b_is_reg,
        .dest_addr, .src_a_addr, .src_b_addr,
        .reg_rd_a, .reg_rd_b, .rdata, .pc,
        .address, .nRead, .nWrite, .halted, .wdata,
        .instr_load, .instr_half, .reg_we, .branch_eval, .pc_advance,
        .reg_wdata, .src_a, .src_b
    );

endmodule

// File: tb/bus_responder.sv
/*
 * Bus slave model: instruction memory, main memory
 * and integer ALU with random busy time
 */
`timescale 1ns/1ps
`include "exec_settings.svh"

module bus_responder #(
    parameter int MAX_POLL = 8
) (
    input  logic                Clk,
    input  logic                nReset,
    input  exec_pkg::bus_addr_t address,
    input  logic                nRead,
    input  logic                nWrite,
    input  exec_pkg::word_t     wdata,
    output exec_pkg::word_t     rdata,
    input  logic                preload_we,
    input  logic                preload_instr,
    input  logic [4:0]          preload_idx,
    input  exec_pkg::word_t     preload_data,
    input  logic [4:0]          peek_idx,
    output exec_pkg::word_t     peek_data
);
    import exec_pkg::*;

    word_t      instr_mem [16];
    word_t      main_mem [32];
    word_t      alu_src1;
    word_t      alu_src2;
    word_t      alu_result;
    logic [3:0] busy;
    logic [3:0] unit;
    pc_t        loc_addr;
    integer     seed = 32'h235f;

    assign unit      = address[15:12];
    assign loc_addr  = address[11:0];
    assign peek_data = main_mem[peek_idx];

    function automatic word_t alu_compute(input logic [7:0] op, input word_t a,
                                          input word_t b);
        case (op)
            `EXEC_OP_IADD:  return a + b;
            `EXEC_OP_ISUB:  return a - b;
            `EXEC_OP_IMULT: return a * b;
            `EXEC_OP_IDIV:  return (b == '0) ? 16'hFFFF : word_t'($signed(a) / $signed(b));
            default:        return '0;
        endcase
    endfunction

    always_comb begin
        rdata = '0;
        if (!nRead) begin
            case (unit)
                // Past the program the fetch sees halt opcodes
                `EXEC_UNIT_INSTR: rdata = (loc_addr < 12'd16) ? instr_mem[loc_addr[3:0]]
                                                               : {8'hFF, loc_addr[7:0]};
                `EXEC_UNIT_MAIN:  rdata = main_mem[loc_addr[11:7]];
                `EXEC_UNIT_INT_ALU: begin
                    if (loc_addr == `EXEC_ALU_STATUS) begin
                        rdata = {{(`EXEC_DATA_WIDTH-1){1'b0}}, busy == 4'd0};
                    end else if (loc_addr == `EXEC_ALU_RESULT) begin
                        rdata = alu_result;
                    end
                end
                default: rdata = '0;
            endcase
        end
    end

    always @(posedge Clk) begin
        if (preload_we) begin
            if (preload_instr) begin
                instr_mem[preload_idx[3:0]] <= preload_data;
            end else begin
                main_mem[preload_idx] <= preload_data;
            end
        end else if (!nWrite && unit == `EXEC_UNIT_MAIN) begin
            main_mem[loc_addr[11:7]] <= wdata;
        end
    end

    always @(posedge Clk or negedge nReset) begin
        if (!nReset) begin
            busy       <= '0;
            alu_src1   <= '0;
            alu_src2   <= '0;
            alu_result <= '0;
        end else begin
            if (busy != 4'd0) begin
                busy <= busy - 4'd1;
            end
            if (!nWrite && unit == `EXEC_UNIT_INT_ALU) begin
                case (loc_addr)
                    `EXEC_ALU_SRC1: alu_src1 <= wdata;
                    `EXEC_ALU_SRC2: alu_src2 <= wdata;
                    `EXEC_ALU_CMD: begin
                        alu_result <= alu_compute(wdata[7:0], alu_src1, alu_src2);
                        busy       <= 4'($unsigned($random(seed)) % MAX_POLL);
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: tb/exec_checker.sv
/*
 * Watches halted and the bus strobes, compares the
 * final memory word per test and counts errors
 */
`timescale 1ns/1ps

module exec_checker (
    input  logic            Clk,
    input  logic            nReset,
    input  logic            nRead,
    input  logic            nWrite,
    input  logic            halted,
    input  logic            check_en,
    input  int              test_num,
    input  logic            exp_halted,
    input  exec_pkg::word_t exp_val,
    input  logic [4:0]      exp_idx,
    input  exec_pkg::word_t mem_word,
    output int              error_count,
    output int              test_count
);
    import exec_pkg::*;

    logic strobe_after_halt;
    logic test_ok;
    int   errors = 0;
    int   tests = 0;

    assign error_count = errors;
    assign test_count  = tests;

    always @(posedge Clk or negedge nReset) begin
        if (!nReset) begin
            strobe_after_halt <= 1'b0;
        end else if (halted && (!nRead || !nWrite)) begin
            strobe_after_halt <= 1'b1;
        end
    end

    always @(posedge Clk) begin
        if (check_en) begin
            test_ok = 1'b1;
            if (halted != exp_halted) begin
                $display("** Error at %0t: test %0d halted = %0b, expected %0b",
                         $time, test_num, halted, exp_halted);
                test_ok = 1'b0;
            end
            if (strobe_after_halt) begin
                $display("Test %0d: a bus strobe appeared after halt", test_num);
                test_ok = 1'b0;
            end
            if (mem_word !== exp_val) begin
                $display("** Error at %0t: test %0d main[%0d] = 0x%h, expected 0x%h",
                         $time, test_num, exp_idx, mem_word, exp_val);
                test_ok = 1'b0;
            end
            $display("Test %0d: %s", test_num, test_ok ? "passed" : "failed");
            tests = tests + 1;
            if (!test_ok) begin
                errors = errors + 1;
            end
        end
    end

endmodule

// File: tb/exec_asserts.sv
/*
 * Bus strobe and halt properties, bound to exec_top
 */
`timescale 1ns/1ps

module exec_asserts (
    input logic Clk,
    input logic nReset,
    input logic nRead,
    input logic nWrite,
    input logic halted
);

    strobes_exclusive: assert property (@(posedge Clk) disable iff (!nReset)
        !(!nRead && !nWrite))
        else $error("nRead and nWrite low together");

    idle_in_reset: assert property (@(posedge Clk) !nReset |-> (nRead && nWrite && !halted))
        else $error("bus not idle during reset");

    halt_sticky: assert property (@(posedge Clk) disable iff (!nReset) halted |=> halted)
        else $error("halted fell without reset");

    quiet_after_halt: assert property (@(posedge Clk) disable iff (!nReset)
        halted |-> (nRead && nWrite))
        else $error("strobe while halted");

endmodule

bind exec_top exec_asserts asserts_i (
    .Clk, .nReset, .nRead, .nWrite, .halted
);

// File: tb/tb_exec.sv
/*
 * Testbench top: clock, reset, program table,
 * test loop, watchdog and final verdict
 */
`timescale 1ns/1ps
`include "exec_settings.svh"

module tb_exec;
    import exec_pkg::*;

    localparam int NUM_TESTS    = 13;
    localparam int PROG_LEN     = 8;
    localparam int MEM_INIT     = 4;
    localparam int MAIN_WORDS   = 32;
    localparam int CLK_PERIOD   = 4;
    localparam int MAX_POLL     = 8;
    localparam int INSTR_CYCLES = 32;
    localparam int SETUP_CYCLES = 64;
    localparam int TEST_CYCLES  = PROG_LEN * (INSTR_CYCLES + MAX_POLL);
    localparam int WATCHDOG_NS  = NUM_TESTS * (TEST_CYCLES + SETUP_CYCLES) * CLK_PERIOD;
    localparam instr_t HALT_W   = {`EXEC_OP_HALT, 24'h000000};
    // Marker store main[3] = main[0] + main[1]
    localparam instr_t MARKER_W = {`EXEC_OP_IADD, 8'h03, 8'h00, 8'h01};

    logic       Clk;
    logic       nReset;
    bus_addr_t  address;
    logic       nRead;
    logic       nWrite;
    word_t      wdata;
    word_t      rdata;
    logic       halted;
    logic       preload_we;
    logic       preload_instr;
    logic [4:0] preload_idx;
    word_t      preload_data;
    logic [4:0] peek_idx;
    word_t      peek_data;
    logic       check_en;
    int         test_num;
    word_t      exp_val;
    logic       exp_halted;
    int         error_count;
    int         test_count;

    // Stimulus and expected values, one row per test
    instr_t     prog_tab [NUM_TESTS][PROG_LEN];
    word_t      mem_tab [NUM_TESTS][MEM_INIT];
    logic [4:0] exp_idx_tab [NUM_TESTS];
    word_t      exp_val_tab [NUM_TESTS];
    logic       exp_halt_tab [NUM_TESTS];

    exec_top dut_i (
        .Clk, .nReset, .address, .nRead, .nWrite, .wdata, .rdata, .halted
    );

    bus_responder #(.MAX_POLL(MAX_POLL)) resp_i (
        .Clk, .nReset, .address, .nRead, .nWrite, .wdata, .rdata,
        .preload_we, .preload_instr, .preload_idx, .preload_data,
        .peek_idx, .peek_data
    );

    exec_checker check_i (
        .Clk, .nReset, .nRead, .nWrite, .halted, .check_en, .test_num,
        .exp_halted, .exp_val, .exp_idx(peek_idx), .mem_word(peek_data),
        .error_count, .test_count
    );

    initial Clk = 1'b0;
    always #(CLK_PERIOD / 2) Clk = ~Clk;

    function automatic instr_t instr(input opcode_t op, input logic [7:0] d,
                                     input logic [7:0] a, input logic [7:0] b);
        return {op, d, a, b};
    endfunction

    task automatic set_test(input int t, input instr_t i0, input instr_t i1,
                            input instr_t i2, input instr_t i3,
                            input word_t m0, input word_t m1, input word_t m2,
                            input word_t m3, input logic [4:0] idx, input word_t val);
        prog_tab[t][0] = i0;
        prog_tab[t][1] = i1;
        prog_tab[t][2] = i2;
        prog_tab[t][3] = i3;
        for (int k = 4; k < PROG_LEN; k++) begin
            prog_tab[t][k] = HALT_W;
        end
        mem_tab[t][0]   = m0;
        mem_tab[t][1]   = m1;
        mem_tab[t][2]   = m2;
        mem_tab[t][3]   = m3;
        exp_idx_tab[t]  = idx;
        exp_val_tab[t]  = val;
        exp_halt_tab[t] = 1'b1;
    endtask

    task automatic preload_word(input logic instr_sel, input logic [4:0] idx,
                                input word_t data);
        preload_we    <= 1'b1;
        preload_instr <= instr_sel;
        preload_idx   <= idx;
        preload_data  <= data;
        @(posedge Clk);
    endtask

    task automatic run_test(input int t);
        int cycles;
        cycles = 0;
        for (int k = 0; k < PROG_LEN; k++) begin
            preload_word(1'b1, 5'(2 * k), prog_tab[t][k][31:16]);
            preload_word(1'b1, 5'(2 * k + 1), prog_tab[t][k][15:0]);
        end
        for (int k = 0; k < MAIN_WORDS; k++) begin
            if (k < MEM_INIT) begin
                preload_word(1'b0, 5'(k), mem_tab[t][k]);
            end else begin
                preload_word(1'b0, 5'(k), {8'hA5, 3'b000, 5'(k)});
            end
        end
        preload_we <= 1'b0;
        nReset     <= 1'b0;
        repeat (3) @(posedge Clk);
        nReset <= 1'b1;
        // halted is combinational from FSM state, look at it mid-cycle
        @(negedge Clk);
        while (!halted && cycles < TEST_CYCLES) begin
            @(negedge Clk);
            cycles++;
        end
        // Watch a few idle cycles for strobes after halt
        repeat (4) @(posedge Clk);
        test_num   <= t;
        peek_idx   <= exp_idx_tab[t];
        exp_val    <= exp_val_tab[t];
        exp_halted <= exp_halt_tab[t];
        check_en   <= 1'b1;
        @(posedge Clk);
        check_en <= 1'b0;
        @(posedge Clk);
    endtask

    initial begin
        nReset        = 1'b0;
        preload_we    = 1'b0;
        preload_instr = 1'b0;
        preload_idx   = '0;
        preload_data  = '0;
        peek_idx      = '0;
        check_en      = 1'b0;
        test_num      = 0;
        exp_val       = '0;
        exp_halted    = 1'b0;

        // Integer ops, memory sources
        set_test(0, instr(`EXEC_OP_IADD, 8'h02, 8'h00, 8'h01), HALT_W, HALT_W, HALT_W,
                 16'h7FFF, 16'h0003, 16'h0000, 16'h0000, 5'd2, 16'h8002);
        set_test(1, instr(`EXEC_OP_ISUB, 8'h02, 8'h00, 8'h01), HALT_W, HALT_W, HALT_W,
                 16'h0003, 16'h0005, 16'h0000, 16'h0000, 5'd2, 16'hFFFE);
        // Register sources loaded by earlier instructions
        set_test(2, instr(`EXEC_OP_IADD, 8'h11, 8'h00, 8'h01),
                 instr(`EXEC_OP_IADD, 8'h12, 8'h02, 8'h03),
                 instr(`EXEC_OP_IMULT, 8'h04, 8'h11, 8'h12), HALT_W,
                 16'h012C, 16'h0000, 16'h00FA, 16'h0000, 5'd4, 16'h24F8);
        set_test(3, instr(`EXEC_OP_IADD, 8'h11, 8'h00, 8'h01),
                 instr(`EXEC_OP_IADD, 8'h12, 8'h02, 8'h03),
                 instr(`EXEC_OP_IDIV, 8'h04, 8'h11, 8'h12), HALT_W,
                 16'hFF9C, 16'h0000, 16'h0007, 16'h0000, 5'd4, 16'hFFF2);
        // Branch at pc 0 with offset 2 lands on the halt between two markers
        set_test(4, instr(`EXEC_OP_BEQ, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'h0005, 16'h0005, 16'h0000, 16'h0000, 5'd3, 16'h0000);
        set_test(5, instr(`EXEC_OP_BEQ, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'h0005, 16'h0006, 16'h0000, 16'h0000, 5'd3, 16'h000B);
        set_test(6, instr(`EXEC_OP_BNE, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'h0005, 16'h0006, 16'h0000, 16'h0000, 5'd3, 16'h0000);
        set_test(7, instr(`EXEC_OP_BLT, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'hFFFE, 16'h0003, 16'h0000, 16'h0000, 5'd3, 16'h0000);
        set_test(8, instr(`EXEC_OP_BLT, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'h0003, 16'hFFFE, 16'h0000, 16'h0000, 5'd3, 16'h0001);
        set_test(9, instr(`EXEC_OP_BGT, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'h0003, 16'hFFFE, 16'h0000, 16'h0000, 5'd3, 16'h0000);
        set_test(10, instr(`EXEC_OP_BGT, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'hFFFE, 16'h0003, 16'h0000, 16'h0000, 5'd3, 16'h0001);
        // Unknown opcode 55 leaves its destination word untouched
        set_test(11, instr(8'h55, 8'h03, 8'h00, 8'h01), HALT_W, HALT_W, HALT_W,
                 16'h0007, 16'h0003, 16'h0000, 16'h1234, 5'd3, 16'h1234);
        set_test(12, instr(`EXEC_OP_BNE, 8'h02, 8'h00, 8'h01), MARKER_W, HALT_W, MARKER_W,
                 16'h0005, 16'h0005, 16'h0000, 16'h0000, 5'd3, 16'h000A);

        @(posedge Clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        repeat (2) @(posedge Clk);
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0 && test_count == NUM_TESTS) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: flist.f
+incdir+design
design/exec_pkg.sv
design/instr_decode.sv
design/reg_file.sv
design/pc_branch.sv
design/bus_sequencer.sv
design/exec_top.sv
tb/bus_responder.sv
tb/exec_checker.sv
tb/exec_asserts.sv
tb/tb_exec.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_exec -o sim_exec
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_exec > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

exit 0
